// ==== alu_stimulus.txt ====
// columns in hex: op a b result carry overflow less more even
// one vector per clock, expected values appear one cycle after the vector
0 00000001 00000002 00000003 0 0 1 0 0
0 FFFFFFFF 00000001 00000000 1 0 0 1 0
0 7FFFFFFF 00000001 80000000 0 1 0 1 0
0 80000000 80000000 00000000 1 1 0 0 1
1 00000005 00000003 00000002 1 0 0 1 0
1 00000003 00000005 FFFFFFFE 0 0 1 0 0
1 80000000 00000001 7FFFFFFF 1 1 0 1 0
1 7FFFFFFF FFFFFFFF 80000000 0 1 1 0 0
1 12345678 12345678 00000000 1 0 0 0 1
2 F0F0A5A5 0FF0FF00 00F0A500 0 0 0 1 0
3 F0F0A5A5 0FF0FF00 FFF0FFA5 0 0 0 1 0
4 F0F0A5A5 0FF0FF00 FF005AA5 0 0 0 1 0
5 12345678 FFFFFFFF EDCBA987 0 0 1 0 0
2 FFFFFFFF FFFFFFFF FFFFFFFF 0 0 0 0 1
6 C0000003 00000000 C0000003 0 0 0 1 0
6 C0000003 00000001 80000006 0 0 0 1 0
6 C0000003 00000011 00060000 0 0 0 1 0
6 C0000003 0000001F 80000000 0 0 0 1 0
6 C0000003 00000020 00000000 0 0 0 1 0
7 C0000003 00000000 C0000003 0 0 0 1 0
7 C0000003 00000001 60000001 0 0 0 1 0
7 C0000003 00000011 00006000 0 0 0 1 0
7 C0000003 0000001F 00000001 0 0 0 1 0
7 C0000003 0000003F 00000000 0 0 0 1 0
8 C0000003 00000000 C0000003 0 0 0 1 0
8 C0000003 00000001 E0000001 0 0 0 1 0
8 C0000003 00000011 FFFFE000 0 0 0 1 0
8 C0000003 0000001F FFFFFFFF 0 0 0 1 0
8 C0000003 00000020 FFFFFFFF 0 0 0 1 0
8 40000000 00000021 00000000 0 0 0 1 0
4 12345678 12345679 00000001 0 0 1 0 0
4 A2345678 12345678 B0000000 0 0 0 1 0
4 12345678 12395678 000D0000 0 0 1 0 0
4 12395678 12345678 000D0000 0 0 0 1 0
4 7FFFFFFF 80000000 FFFFFFFF 0 0 1 0 0
9 12345678 12345678 00000000 0 0 0 0 1
F FFFFFFFF 00000001 00000000 0 0 0 1 0
C 00000001 80000000 00000000 0 0 1 0 0

// ==== compile.f ====
+incdir+.
alu_pkg.sv
cla_group_4.sv
cla_adder_32.sv
barrel_shifter.sv
magnitude_comparator.sv
alu_top.sv
alu_checker.sv
alu_tb.sv

// ==== Makefile ====
# Verilator flow for the 32-bit alu testbench

TOP = alu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP) -Mdir obj_dir

# pass only when the run prints the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== alu_tb.sv ====
// alu testbench
// applies the vectors of alu_stimulus.txt one per clock to the 32-bit alu
// and checks result and flags one cycle later

`timescale 1ns/100ps

`include "alu_settings.svh"

module alu_tb;

	localparam int EDGE_TIMEOUT = 25; // 1 ns polls allowed per clock edge

	logic             clk;
	logic             rst;
	alu_pkg::alu_op_t op;
	alu_pkg::word_t   a;
	alu_pkg::word_t   b;
	alu_pkg::word_t   result;
	logic             carry;
	logic             overflow;
	logic             less;
	logic             more;
	logic             even;

	// vectors from the stimulus file
	alu_pkg::alu_op_t vec_op[$];
	alu_pkg::word_t   vec_a[$];
	alu_pkg::word_t   vec_b[$];
	alu_pkg::word_t   vec_res[$];
	logic [4:0]       vec_flags[$]; // carry overflow less more even
	int               pass_count;
	int               fail_count;

	alu_top alu_top_i (
		.clk(clk), .rst(rst), .op(op), .a(a), .b(b),
		.result(result), .carry(carry), .overflow(overflow),
		.less(less), .more(more), .even(even)
	);

	bind alu_top alu_checker alu_checker_i (
		.clk(clk), .rst(rst), .op(op), .a(a), .b(b),
		.result(result), .carry(carry), .overflow(overflow),
		.less(less), .more(more), .even(even)
	);

	always #5 clk = ~clk; // 10 ns period

	function automatic string op_name(input alu_pkg::alu_op_t code);
		case (code)
			`ALU_OP_ADD: return "add";
			`ALU_OP_SUB: return "sub";
			`ALU_OP_AND: return "and";
			`ALU_OP_OR:  return "or";
			`ALU_OP_XOR: return "xor";
			`ALU_OP_NOT: return "not";
			`ALU_OP_SLL: return "sll";
			`ALU_OP_SRL: return "srl";
			`ALU_OP_SRA: return "sra";
			default:     return "unused";
		endcase
	endfunction

	// wait for the next rising edge, return 1 ns after it
	// polls sit on the half ns so none lands on an edge
	task automatic advance_cycle(output bit ok);
		bit seen_low;
		int ticks;
		seen_low = 1'b0;
		ok       = 1'b0;
		ticks    = 0;
		#0.5;
		while (!ok && ticks < EDGE_TIMEOUT)
		begin
			if (clk == 1'b0)
				seen_low = 1'b1;
			else if (seen_low)
				ok = 1'b1; // low then high, edge passed
			if (!ok)
			begin
				#1;
				ticks++;
			end
		end
		#0.5; // edge + 1 ns
	endtask

	// columns: op a b result carry overflow less more even, all hex
	task automatic load_vectors(output bit ok);
		int          fd;
		int          code;
		string       line;
		logic [31:0] f_op;
		logic [31:0] f_a;
		logic [31:0] f_b;
		logic [31:0] f_res;
		logic [31:0] f_c;
		logic [31:0] f_v;
		logic [31:0] f_lt;
		logic [31:0] f_gt;
		logic [31:0] f_eq;
		ok = 1'b0;
		fd = $fopen("alu_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file alu_stimulus.txt");
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			code = $fgets(line, fd);
			if (code == 0 || line.len() < 2 || line.substr(0, 1) == "//")
				continue; // blank or comment
			code = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
				f_op, f_a, f_b, f_res, f_c, f_v, f_lt, f_gt, f_eq);
			if (code != 9)
			begin
				$display("stimulus line %0d has %0d fields instead of 9",
					vec_op.size() + 1, code);
				$fclose(fd);
				return;
			end
			vec_op.push_back(f_op[3:0]);
			vec_a.push_back(f_a);
			vec_b.push_back(f_b);
			vec_res.push_back(f_res);
			vec_flags.push_back({f_c[0], f_v[0], f_lt[0], f_gt[0], f_eq[0]});
		end
		$fclose(fd);
		ok = (vec_op.size() > 0);
		if (!ok)
			$display("the stimulus file holds no vectors");
	endtask

	task automatic reset_dut(output bit ok);
		ok  = 1'b1;
		rst = 1'b1;
		for (int n = 0; n < 4 && ok; n++) // four reset edges
			advance_cycle(ok);
		if (!ok)
			$display("timeout: the clock stopped during reset");
		rst = 1'b0;
	endtask

	// after reset every output register reads zero, even included
	task automatic check_reset();
		if (result !== '0 || {carry, overflow, less, more, even} !== 5'b0)
		begin
			$display("Fail at %0t: reset left result %h flags %b", $realtime,
				result, {carry, overflow, less, more, even});
			fail_count++;
			$display("reset check failed");
		end
		else
		begin
			pass_count++;
			$display("reset check passed");
		end
	endtask

	task automatic check_vector(input int idx);
		logic [4:0] got_flags;
		bit         good;
		got_flags = {carry, overflow, less, more, even};
		good      = 1'b1;
		if (result !== vec_res[idx])
		begin
			$display("Fail at %0t: vector %0d %s result %h, expected %h", $realtime,
				idx, op_name(vec_op[idx]), result, vec_res[idx]);
			good = 1'b0;
		end
		if (got_flags !== vec_flags[idx])
		begin
			$display("Fail at %0t: vector %0d %s flags c v lt gt eq %b, expected %b",
				$realtime, idx, op_name(vec_op[idx]), got_flags, vec_flags[idx]);
			good = 1'b0;
		end
		if (good)
			pass_count++;
		else
			fail_count++;
		$display("vector %0d %s %s", idx, op_name(vec_op[idx]), good ? "passed" : "failed");
	endtask

	// one vector per cycle, each checked one edge after it is driven
	task automatic run_vectors(output bit ok);
		ok = 1'b1;
		for (int i = 0; i < vec_op.size() && ok; i++)
		begin
			op = vec_op[i];
			a  = vec_a[i];
			b  = vec_b[i];
			advance_cycle(ok);
			if (!ok)
				$display("timeout: no clock edge after vector %0d", i);
			else
				check_vector(i);
		end
	endtask

	initial
	begin
		bit ok;
		$timeformat(-9, 1, " ns", 0);
		clk        = 1'b0;
		rst        = 1'b1;
		op         = '0;
		a          = '0;
		b          = '0;
		pass_count = 0;
		fail_count = 0;
		load_vectors(ok);
		if (ok)
			reset_dut(ok);
		if (ok)
			check_reset();
		if (ok)
			run_vectors(ok);
		$display("checks passed %0d, failed %0d, run %s", pass_count, fail_count,
			ok ? "complete" : "stopped early");
		if (ok && fail_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== alu_checker.sv ====
// alu checker
// concurrent assertions on the alu ports, bound into alu_top

`timescale 1ns/100ps

`include "alu_settings.svh"

module alu_checker
(
	input logic             clk,
	input logic             rst,
	input alu_pkg::alu_op_t op,
	input alu_pkg::word_t   a,
	input alu_pkg::word_t   b,
	input alu_pkg::word_t   result,
	input logic             carry,
	input logic             overflow,
	input logic             less,
	input logic             more,
	input logic             even
);

	logic armed; // set once a reset edge has been seen, masks start-up

	always_ff @(posedge clk)
	begin
		if (rst)
			armed <= 1'b1;
	end

	// compare flags are one-hot after every computing cycle
	a_one_flag: assert property (@(posedge clk)
		armed && !$past(rst) |-> $onehot({less, more, even}))
		else $error("compare flags not one-hot");

	a_even_equal: assert property (@(posedge clk)
		armed && !$past(rst) |-> even == ($past(a) == $past(b)))
		else $error("even does not follow a == b");

	// adder flags only for ADD and SUB
	a_flag_gate: assert property (@(posedge clk)
		armed && !$past(rst) && $past(op) != `ALU_OP_ADD && $past(op) != `ALU_OP_SUB
		|-> !carry && !overflow)
		else $error("carry or overflow set outside add and sub");

	a_reset_clear: assert property (@(posedge clk)
		armed && $past(rst) |-> (result == '0) && !carry && !overflow && !less && !more && !even)
		else $error("outputs not cleared by reset");

endmodule

// ==== alu_top.sv ====
// alu top
// 32-bit alu: adder, shifter, comparator and bitwise logic,
// result and flags registered once on clk for one-cycle latency

`timescale 1ns/100ps

`include "alu_settings.svh"

module alu_top
(
	input  logic             clk,
	input  logic             rst,
	input  alu_pkg::alu_op_t op,
	input  alu_pkg::word_t   a,
	input  alu_pkg::word_t   b,
	output alu_pkg::word_t   result,
	output logic             carry,
	output logic             overflow,
	output logic             less,
	output logic             more,
	output logic             even
);

	logic            sub;       // adder subtract level
	logic            arith_op;  // ADD or SUB, gates the adder flags
	alu_pkg::word_t  sum;
	logic            add_carry;
	logic            add_ovf;
	alu_pkg::word_t  shl;
	alu_pkg::word_t  shr_logic;
	alu_pkg::word_t  shr_arith;
	logic            cmp_less;
	logic            cmp_more;
	logic            cmp_even;
	alu_pkg::word_t  sel_result; // selected word before the register

	assign sub      = (op == `ALU_OP_SUB);
	assign arith_op = (op == `ALU_OP_ADD) || sub;

	cla_adder_32 cla_adder_32_i (
		.a(a), .b(b), .sub(sub),
		.sum(sum), .carry(add_carry), .overflow(add_ovf)
	);

	barrel_shifter barrel_shifter_i (
		.value(a),
		.amount(b[`ALU_SHAMT_WIDTH-1:0]), // b[5:0], upper bits of b ignored
		.shl(shl), .shr_logic(shr_logic), .shr_arith(shr_arith)
	);

	magnitude_comparator magnitude_comparator_i (
		.a(a), .b(b),
		.less(cmp_less), .more(cmp_more), .even(cmp_even)
	);

	// word select, bitwise ops done in place
	always_comb
	begin
		case (op)
			`ALU_OP_ADD, `ALU_OP_SUB: sel_result = sum;
			`ALU_OP_AND: sel_result = a & b;
			`ALU_OP_OR:  sel_result = a | b;
			`ALU_OP_XOR: sel_result = a ^ b;
			`ALU_OP_NOT: sel_result = ~a;
			`ALU_OP_SLL: sel_result = shl;
			`ALU_OP_SRL: sel_result = shr_logic;
			`ALU_OP_SRA: sel_result = shr_arith;
			default:     sel_result = '0; // codes 9..15
		endcase
	end

	// output stage, compare flags follow a and b for every code
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			result   <= '0;
			carry    <= 1'b0;
			overflow <= 1'b0;
			less     <= 1'b0;
			more     <= 1'b0;
			even     <= 1'b0; // cleared too, not set by equal zeros
		end
		else
		begin
			result   <= sel_result;
			carry    <= add_carry & arith_op; // on SUB, 1 means no borrow
			overflow <= add_ovf & arith_op;
			less     <= cmp_less;
			more     <= cmp_more;
			even     <= cmp_even;
		end
	end

endmodule

// ==== magnitude_comparator.sv ====
// magnitude comparator
// unsigned compare of a and b through a tree of 4-bit lookahead cells

`timescale 1ns/100ps

module magnitude_comparator
(
	input  alu_pkg::word_t a,
	input  alu_pkg::word_t b,
	output logic           less,
	output logic           more,
	output logic           even
);

	alu_pkg::word_t lt_bit; // per bit a=0 b=1
	alu_pkg::word_t gt_bit; // per bit a=1 b=0
	logic [7:0]     l1_lt;  // per nibble
	logic [7:0]     l1_gt;
	logic [1:0]     l2_lt;  // per half word
	logic [1:0]     l2_gt;

	// lookahead cell, the highest differing position decides
	function automatic logic [1:0] cmp_cell(input alu_pkg::nibble_t lt,
		input alu_pkg::nibble_t gt);
		alu_pkg::nibble_t diff;
		alu_pkg::nibble_t hit;
		diff   = lt | gt;
		hit[3] = diff[3];
		hit[2] = ~diff[3] & diff[2];
		hit[1] = ~diff[3] & ~diff[2] & diff[1];
		hit[0] = ~diff[3] & ~diff[2] & ~diff[1] & diff[0];
		return {|(hit & lt), |(hit & gt)}; // {less, more}
	endfunction

	assign lt_bit = ~a & b;
	assign gt_bit = a & ~b;

	genvar i;
	generate
		for (i = 0; i < 8; i++)
		begin : level1
			assign {l1_lt[i], l1_gt[i]} = cmp_cell(lt_bit[4*i +: 4], gt_bit[4*i +: 4]);
		end
		for (i = 0; i < 2; i++)
		begin : level2
			assign {l2_lt[i], l2_gt[i]} = cmp_cell(l1_lt[4*i +: 4], l1_gt[4*i +: 4]);
		end
	endgenerate

	// final pair, upper half wins when it differs
	assign less = l2_lt[1] | (~l2_gt[1] & l2_lt[0]);
	assign more = l2_gt[1] | (~l2_lt[1] & l2_gt[0]);
	assign even = ~(less | more);

endmodule

// ==== barrel_shifter.sv ====
// barrel shifter
// five-stage logarithmic shifter, left, logical right and arithmetic right
// all at once; amount bit 5 gives the full fill value

`timescale 1ns/100ps

`include "alu_settings.svh"

module barrel_shifter
(
	input  alu_pkg::word_t  value,
	input  alu_pkg::shamt_t amount,
	output alu_pkg::word_t  shl,
	output alu_pkg::word_t  shr_logic,
	output alu_pkg::word_t  shr_arith
);

	localparam int STAGES = `ALU_SHAMT_WIDTH - 1; // 1, 2, 4, 8, 16
	localparam int MSB    = `ALU_WIDTH - 1;

	alu_pkg::word_t sl  [0:STAGES]; // left path
	alu_pkg::word_t srl [0:STAGES]; // right path, zero fill
	alu_pkg::word_t sra [0:STAGES]; // right path, sign fill
	logic           sign;

	assign sign   = value[MSB];
	assign sl[0]  = value;
	assign srl[0] = value;
	assign sra[0] = value;

	genvar s;
	generate
		for (s = 0; s < STAGES; s++)
		begin : stage
			localparam int STEP = 1 << s;

			// each stage moves by STEP or passes through
			assign sl[s+1] = amount[s] ? {sl[s][MSB-STEP:0], {STEP{1'b0}}} : sl[s];
			assign srl[s+1] = amount[s] ? {{STEP{1'b0}}, srl[s][MSB:STEP]} : srl[s];
			assign sra[s+1] = amount[s] ? {{STEP{sign}}, sra[s][MSB:STEP]} : sra[s];
		end
	endgenerate

	// 32 or more shifts everything out
	assign shl       = amount[STAGES] ? '0 : sl[STAGES];
	assign shr_logic = amount[STAGES] ? '0 : srl[STAGES];
	assign shr_arith = amount[STAGES] ? {`ALU_WIDTH{sign}} : sra[STAGES];

endmodule

// ==== cla_adder_32.sv ====
// cla adder 32
// two-level carry-lookahead add/subtract over eight 4-bit groups,
// gives carry out and signed overflow

`timescale 1ns/100ps

module cla_adder_32
(
	input  alu_pkg::word_t a,
	input  alu_pkg::word_t b,
	input  logic           sub, // 1 gives a - b
	output alu_pkg::word_t sum,
	output logic           carry,
	output logic           overflow
);

	logic [7:0] gp;      // group propagate
	logic [7:0] gg;      // group generate
	logic [8:0] group_c; // carry into each group, [8] is carry out
	logic       top_msb; // carry into bit 31
	logic       acc_g;   // running generate term
	logic       acc_p;   // running propagate product

	genvar i;
	generate
		for (i = 0; i < 8; i++)
		begin : grp
			if (i == 7)
			begin : top
				cla_group_4 cla_group_4_i (
					.a(a[4*i +: 4]), .b(b[4*i +: 4]), .sub(sub),
					.carry_in(group_c[i]), .sum(sum[4*i +: 4]),
					.group_p(gp[i]), .group_g(gg[i]),
					.carry_msb(top_msb)
				);
			end
			else
			begin : low
				cla_group_4 cla_group_4_i (
					.a(a[4*i +: 4]), .b(b[4*i +: 4]), .sub(sub),
					.carry_in(group_c[i]), .sum(sum[4*i +: 4]),
					.group_p(gp[i]), .group_g(gg[i]),
					.carry_msb() // only the top group feeds overflow
				);
			end
		end
	endgenerate

	// second level, each group carry expanded from sub and the G/P pairs below it
	always_comb
	begin
		group_c[0] = sub; // two's complement +1 on subtract
		for (int k = 1; k <= 8; k++)
		begin
			acc_g = gg[k-1];
			acc_p = gp[k-1];
			for (int j = k - 2; j >= 0; j--)
			begin
				acc_g = acc_g | (acc_p & gg[j]); // generate from lower group
				acc_p = acc_p & gp[j];
			end
			group_c[k] = acc_g | (acc_p & sub);
		end
	end

	assign carry    = group_c[8];
	assign overflow = top_msb ^ group_c[8]; // carry in vs out of the sign bit

endmodule

// ==== cla_group_4.sv ====
// cla group 4
// 4-bit add/subtract slice with inner lookahead carries,
// group propagate/generate and the carry into its top bit

`timescale 1ns/100ps

module cla_group_4
(
	input  alu_pkg::nibble_t a,
	input  alu_pkg::nibble_t b,
	input  logic             sub, // invert b for subtraction
	input  logic             carry_in,
	output alu_pkg::nibble_t sum,
	output logic             group_p,
	output logic             group_g,
	output logic             carry_msb // carry into bit 3, for overflow
);

	alu_pkg::nibble_t b_eff; // b or ~b
	alu_pkg::nibble_t p;     // bit propagate
	alu_pkg::nibble_t g;     // bit generate
	alu_pkg::nibble_t c;     // carry into each bit

	assign b_eff = b ^ {4{sub}};
	assign p     = a ^ b_eff;
	assign g     = a & b_eff;

	// inner carries all from carry_in, no ripple
	assign c[0] = carry_in;
	assign c[1] = g[0] | (p[0] & carry_in);
	assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & carry_in);
	assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
		| (p[2] & p[1] & p[0] & carry_in);

	assign sum = p ^ c;

	// group terms for the second lookahead level
	assign group_p = &p;
	assign group_g = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
		| (p[3] & p[2] & p[1] & g[0]);

	assign carry_msb = c[3];

endmodule

// ==== alu_pkg.sv ====
// alu package
// shared vector types for the alu datapath and its testbench

`include "alu_settings.svh"

package alu_pkg;

	// operand or result word
	typedef logic [`ALU_WIDTH-1:0] word_t;

	// operation code, 16 encodings of which 9 are used
	typedef logic [3:0] alu_op_t;

	// shift amount, low bits of b
	typedef logic [`ALU_SHAMT_WIDTH-1:0] shamt_t;

	// 4-bit slice for the adder groups and compare cells
	typedef logic [3:0] nibble_t;

endpackage

// ==== alu_settings.svh ====
// alu settings
// data width, shift amount width and the operation codes of the 32-bit alu

`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// datapath width, lookahead trees are laid out for 32 only
`define ALU_WIDTH 32

// shift amount taken from the low bits of b, bit 5 means 32 or more
`define ALU_SHAMT_WIDTH 6

// operation codes
`define ALU_OP_ADD 4'd0 // a + b
`define ALU_OP_SUB 4'd1 // a - b
`define ALU_OP_AND 4'd2 // a & b
`define ALU_OP_OR 4'd3 // a | b
`define ALU_OP_XOR 4'd4 // a ^ b
`define ALU_OP_NOT 4'd5 // ~a, b ignored
`define ALU_OP_SLL 4'd6 // a << b[5:0]
`define ALU_OP_SRL 4'd7 // a >> b[5:0], zero fill
`define ALU_OP_SRA 4'd8 // a >>> b[5:0], sign fill
// codes 9 to 15 are unused and give zero

`endif
